// File: rtl/patch_correlator.sv
`timescale 1ns/1ns
`default_nettype none

module patch_correlator (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               ack,
	input  logic               done,
	input  logic               pix_valid,
	input  logic [31:0]        pix_data,
	output tm_pkg::beat_idx_t  rd_idx,
	input  tm_pkg::tmpl_word_t rd_word,
	output tm_pkg::score_t     score,
	output logic               score_valid
);
	import tm_pkg::*;

	logic                         loaded;		// a full template is in the store.
	beat_idx_t                    beat_cnt;
	score_t                       acc;
	score_t                       beat_sum;
	logic                         accept;
	logic                         last_beat;
	tmpl_px_t [PX_PER_WORD-1:0]   tpx;
	logic signed [17:0]           prod [PX_PER_WORD];

	assign tpx       = rd_word;
	assign rd_idx    = beat_cnt;
	assign accept    = loaded & pix_valid & ~ack;
	assign last_beat = (beat_cnt == beat_idx_t'(TMPL_WORDS - 1));

	// signed template pixel times unsigned image pixel.
	always_comb begin
		beat_sum = '0;
		for (int i = 0; i < PX_PER_WORD; i++) begin
			prod[i]  = tpx[i] * $signed({1'b0, pix_data[8*i +: 8]});
			beat_sum = beat_sum + score_t'(prod[i]);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			loaded <= 1'b0;
		end else if (ack) begin
			loaded <= 1'b0;	// store is being rewritten.
		end else if (done) begin
			loaded <= 1'b1;
		end
	end

	// a reload drops any partial patch.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			beat_cnt    <= '0;
			acc         <= '0;
			score_valid <= 1'b0;
		end else begin
			score_valid <= 1'b0;
			if (ack) begin
				beat_cnt <= '0;
				acc      <= '0;
			end else if (accept) begin
				beat_cnt <= beat_cnt + 1'b1;	// wraps to the next patch.
				if (last_beat) begin
					acc         <= '0;
					score_valid <= 1'b1;
				end else begin
					acc <= acc + beat_sum;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept && last_beat) begin
			score <= acc + beat_sum;
		end
	end

endmodule : patch_correlator

`default_nettype wire

// File: rtl/peak_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module peak_tracker #(
	parameter int NUM_PATCHES = 4
) (
	input  logic           clk,
	input  logic           rst_n,
	input  tm_pkg::score_t score,
	input  logic           score_valid,
	output tm_pkg::score_t best_score,
	output logic [7:0]     best_index,
	output logic           result_valid
);
	import tm_pkg::*;

	logic [7:0] patch_cnt;	// position in the frame.
	score_t     best_reg;
	logic [7:0] idx_reg;
	logic       first;
	logic       last;
	logic       take;

	assign first = (patch_cnt == 8'd0);
	assign last  = (patch_cnt == 8'(NUM_PATCHES - 1));
	assign take  = first || (score > best_reg);	// strict, so a tie keeps the earlier one.

	// current patch is already folded into the reported best.
	assign best_score   = take ? score : best_reg;
	assign best_index   = take ? patch_cnt : idx_reg;
	assign result_valid = score_valid & last;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			patch_cnt <= '0;
		end else if (score_valid) begin
			patch_cnt <= last ? 8'd0 : patch_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (score_valid && take) begin
			best_reg <= score;
			idx_reg  <= patch_cnt;
		end
	end

endmodule : peak_tracker

`default_nettype wire

// File: rtl/template_handler.sv
`timescale 1ns/1ns
`default_nettype none

module template_handler (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               en,
	input  logic [31:0]        rdata,
	output tm_pkg::row_t       row,
	output tm_pkg::col_t       col,
	output logic               inst,
	output logic               ack,
	output logic               done,
	output tm_pkg::tmpl_beat_t beat
);
	import tm_pkg::*;

	handler_state_t cs, ns;
	row_t           store_row;	// coordinates of the word now on rdata.
	col_t           store_col;
	logic [7:0]     store_avg;
	logic [7:0]     avg;
	tmpl_word_t     zm_word;

	function automatic tmpl_px_t zero_mean(input logic [7:0] px, input logic [7:0] lvl);
		return tmpl_px_t'({1'b0, px}) - tmpl_px_t'({1'b0, lvl});
	endfunction

	always_comb begin
		zm_word.px0 = zero_mean(rdata[7:0], store_avg);
		zm_word.px1 = zero_mean(rdata[15:8], store_avg);
		zm_word.px2 = zero_mean(rdata[23:16], store_avg);
		zm_word.px3 = zero_mean(rdata[31:24], store_avg);
	end

	// every PROC cycle carries one word.
	always_comb begin
		beat.wr   = (cs == PROC);
		beat.idx  = {store_row, store_col};
		beat.word = zm_word;
	end

	always_comb begin
		ns   = cs;
		row  = '0;
		col  = '0;
		inst = 1'b0;
		ack  = 1'b0;
		done = 1'b0;
		avg  = store_avg;
		unique case (cs)
			INIT: begin
				if (en) begin
					ack  = 1'b1;
					inst = 1'b1;	// fetch the average first.
					ns   = LOAD;
				end
			end
			LOAD: begin
				avg = rdata[31:24];	// average lives in the top byte.
				ns  = PROC;		// row 0, col 0 requested here.
			end
			PROC: begin
				if (store_col == col_t'(TMPL_COLS - 1)) begin
					if (store_row == row_t'(TMPL_ROWS - 1)) begin
						done = 1'b1;	// last word is on rdata.
						ns   = INIT;
					end else begin
						row = store_row + 1'b1;
					end
				end else begin
					row = store_row;
					col = store_col + 1'b1;
				end
			end
			default: ns = INIT;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cs        <= INIT;
			store_row <= '0;
			store_col <= '0;
			store_avg <= '0;
		end else begin
			cs        <= ns;
			store_row <= row;
			store_col <= col;
			store_avg <= avg;
		end
	end

endmodule : template_handler

`default_nettype wire

// File: rtl/template_matcher.sv
`timescale 1ns/1ns
`default_nettype none

module template_matcher #(
	parameter int NUM_PATCHES = 4
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              en,
	input  logic              tm_wr,
	input  tm_pkg::mem_addr_t tm_addr,
	input  logic [31:0]       tm_wdata,
	input  logic              pix_valid,
	input  logic [31:0]       pix_data,
	output logic              ack,
	output logic              done,
	output tm_pkg::score_t    score,
	output logic              score_valid,
	output tm_pkg::score_t    best_score,
	output logic [7:0]        best_index,
	output logic              result_valid
);
	import tm_pkg::*;

	row_t        row;
	col_t        col;
	logic        inst;
	logic [31:0] rdata;
	tmpl_beat_t  beat;
	beat_idx_t   rd_idx;
	tmpl_word_t  rd_word;

	template_mem u_template_mem (
		.clk      (clk),
		.rst_n    (rst_n),
		.tm_wr    (tm_wr),
		.tm_addr  (tm_addr),
		.tm_wdata (tm_wdata),
		.row      (row),
		.col      (col),
		.inst     (inst),
		.rdata    (rdata)
	);

	template_handler u_template_handler (
		.clk   (clk),
		.rst_n (rst_n),
		.en    (en),
		.rdata (rdata),
		.row   (row),
		.col   (col),
		.inst  (inst),
		.ack   (ack),
		.done  (done),
		.beat  (beat)
	);

	template_store u_template_store (
		.clk     (clk),
		.rst_n   (rst_n),
		.beat    (beat),
		.rd_idx  (rd_idx),
		.rd_word (rd_word)
	);

	patch_correlator u_patch_correlator (
		.clk         (clk),
		.rst_n       (rst_n),
		.ack         (ack),
		.done        (done),
		.pix_valid   (pix_valid),
		.pix_data    (pix_data),
		.rd_idx      (rd_idx),
		.rd_word     (rd_word),
		.score       (score),
		.score_valid (score_valid)
	);

	peak_tracker #(
		.NUM_PATCHES (NUM_PATCHES)
	) u_peak_tracker (
		.clk          (clk),
		.rst_n        (rst_n),
		.score        (score),
		.score_valid  (score_valid),
		.best_score   (best_score),
		.best_index   (best_index),
		.result_valid (result_valid)
	);

endmodule : template_matcher

`default_nettype wire

// File: rtl/template_mem.sv
`timescale 1ns/1ns
`default_nettype none

module template_mem (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              tm_wr,
	input  tm_pkg::mem_addr_t tm_addr,
	input  logic [31:0]       tm_wdata,
	input  tm_pkg::row_t      row,
	input  tm_pkg::col_t      col,
	input  logic              inst,
	output logic [31:0]       rdata
);
	import tm_pkg::*;

	logic [31:0] mem [0:TMPL_WORDS];	// average word plus 64 pixel words.
	mem_addr_t   rd_addr;

	// pixel words start right after the average.
	assign rd_addr = inst ? mem_addr_t'(AVG_ADDR)
			: mem_addr_t'(int'(row) * TMPL_COLS + int'(col) + 1);

	always_ff @(posedge clk) begin
		if (tm_wr && (tm_addr <= mem_addr_t'(TMPL_WORDS))) begin
			mem[tm_addr] <= tm_wdata;
		end
	end

	// read before write on a collision.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rdata <= '0;
		end else begin
			rdata <= mem[rd_addr];
		end
	end

endmodule : template_mem

`default_nettype wire

// File: rtl/template_store.sv
`timescale 1ns/1ns
`default_nettype none

module template_store (
	input  logic               clk,
	input  logic               rst_n,
	input  tm_pkg::tmpl_beat_t beat,
	input  tm_pkg::beat_idx_t  rd_idx,
	output tm_pkg::tmpl_word_t rd_word
);
	import tm_pkg::*;

	tmpl_word_t words [TMPL_WORDS];	// zero-mean template.

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < TMPL_WORDS; i++) begin
				words[i] <= '0;
			end
		end else if (beat.wr) begin
			words[beat.idx] <= beat.word;
		end
	end

	// combinational read for the correlator.
	assign rd_word = words[rd_idx];

endmodule : template_store

`default_nettype wire

// File: rtl/tm_pkg.sv
`default_nettype none

package tm_pkg;

	// template geometry.
	localparam int TMPL_ROWS   = 16;	// pixel rows per template.
	localparam int TMPL_COLS   = 4;		// memory words per row.
	localparam int TMPL_WORDS  = 64;	// pixel words per template.
	localparam int PX_PER_WORD = 4;		// 8-bit pixels packed in one word.

	localparam int AVG_ADDR = 0;		// word holding the average, pixels follow.

	typedef logic [6:0] mem_addr_t;
	typedef logic [3:0] row_t;
	typedef logic [1:0] col_t;
	typedef logic [5:0] beat_idx_t;		// row * 4 + col.

	typedef logic signed [8:0] tmpl_px_t;	// pixel minus average.

	// pixel 0 sits in the low bits, as byte 0 does in memory.
	typedef struct packed {
		tmpl_px_t px3;
		tmpl_px_t px2;
		tmpl_px_t px1;
		tmpl_px_t px0;
	} tmpl_word_t;

	typedef struct packed {
		logic       wr;		// store write strobe.
		beat_idx_t  idx;	// destination word.
		tmpl_word_t word;	// four zero-mean pixels.
	} tmpl_beat_t;

	// 256 products below 2^16 in magnitude fit in 26 signed bits.
	typedef logic signed [25:0] score_t;

	typedef enum logic [1:0] {
		INIT,
		LOAD,
		PROC
	} handler_state_t;

endpackage : tm_pkg

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# compile the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module template_matcher_tb \
	-f template_matcher.f \
	-o sim_template_matcher
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/sim_template_matcher
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0

// File: tb/template_matcher_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module template_matcher_assertions #(
	parameter int NUM_PATCHES = 4
) (
	input logic clk,
	input logic rst_n,
	input logic ack,
	input logic done,
	input logic score_valid,
	input logic result_valid
);

	int scores_seen;	// score pulses since reset.

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scores_seen <= 0;
		end else if (score_valid) begin
			scores_seen <= scores_seen + 1;
		end
	end

	done_single: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
		else $error("done stayed high for more than one cycle");

	// LOAD plus 64 PROC cycles.
	ack_to_done: assert property (@(posedge clk) disable iff (!rst_n)
		ack |-> ##65 done)
		else $error("done did not follow ack after 64 cycles");

	// every NUM_PATCHES-th score closes a frame, and no other one does.
	frame_result: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid == (score_valid && (scores_seen % NUM_PATCHES == NUM_PATCHES - 1)))
		else $error("result_valid did not match the last score of a frame");

endmodule : template_matcher_assertions

bind template_matcher template_matcher_assertions #(
	.NUM_PATCHES (NUM_PATCHES)
) u_template_matcher_assertions (.*);

`default_nettype wire

// File: tb/template_matcher_tb.sv
`timescale 1ns/1ns
`default_nettype none

module template_matcher_tb;
	import tm_pkg::*;

	localparam int NUM_PATCHES = 4;
	localparam int PATCH_PX    = 256;	// pixels per patch and per template.
	localparam int MAX_CYCLES  = 4000;	// about three times the length of the tests.

	logic        clk;
	logic        rst_n;
	logic        en;
	logic        tm_wr;
	mem_addr_t   tm_addr;
	logic [31:0] tm_wdata;
	logic        pix_valid;
	logic [31:0] pix_data;
	logic        ack;
	logic        done;
	score_t      score;
	logic        score_valid;
	score_t      best_score;
	logic [7:0]  best_index;
	logic        result_valid;

	logic [7:0]  tmpl_px [PATCH_PX];	// template as written, row major.
	logic [7:0]  tmpl_avg;
	logic [7:0]  img [NUM_PATCHES][PATCH_PX];	// patches of the current frame.
	int          exp_scores [$];
	int          exp_best [$];
	int          exp_index [$];
	int          cyc;

	template_matcher #(
		.NUM_PATCHES (NUM_PATCHES)
	) u_template_matcher (
		.clk          (clk),
		.rst_n        (rst_n),
		.en           (en),
		.tm_wr        (tm_wr),
		.tm_addr      (tm_addr),
		.tm_wdata     (tm_wdata),
		.pix_valid    (pix_valid),
		.pix_data     (pix_data),
		.ack          (ack),
		.done         (done),
		.score        (score),
		.score_valid  (score_valid),
		.best_score   (best_score),
		.best_index   (best_index),
		.result_valid (result_valid)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic abort(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "%s", why);
	endtask

	task automatic check(input string name, input int actual, input int expected);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, actual, expected);
			abort("value mismatch");
		end
	endtask

	// sum of (template pixel - average) * image pixel.
	function automatic int ref_score(input int p);
		int sum;
		sum = 0;
		for (int k = 0; k < PATCH_PX; k++) begin
			sum += (int'(tmpl_px[k]) - int'(tmpl_avg)) * int'(img[p][k]);
		end
		return sum;
	endfunction

	function automatic int best_of(input int s [NUM_PATCHES]);
		int idx;
		idx = 0;
		for (int p = 1; p < NUM_PATCHES; p++) begin
			if (s[p] > s[idx]) begin
				idx = p;	// a tie stays with the earlier patch.
			end
		end
		return idx;
	endfunction

	task automatic write_template(input logic [7:0] avg);
		tmpl_avg = avg;
		for (int k = 0; k < PATCH_PX; k++) begin
			tmpl_px[k] = 8'($urandom);
		end
		for (int a = 0; a <= TMPL_WORDS; a++) begin
			@(negedge clk);
			tm_wr   = 1'b1;
			tm_addr = mem_addr_t'(a);
			if (a == AVG_ADDR) begin
				tm_wdata = {avg, 24'($urandom)};	// only the top byte counts.
			end else begin
				tm_wdata = {tmpl_px[4*a-1], tmpl_px[4*a-2], tmpl_px[4*a-3], tmpl_px[4*a-4]};
			end
		end
		@(negedge clk);
		tm_wr = 1'b0;
	endtask

	task automatic load_template();
		int wait_cyc;
		@(negedge clk);
		en = 1'b1;
		#10;
		check("ack", int'(ack), 1);
		wait_cyc = 0;
		do begin
			@(negedge clk);
			en = 1'b0;
			#10;
			wait_cyc++;
		end while (!done);
		// done opens the cycle 64 edges after the one that took en.
		check("done_delay", wait_cyc, 65);
	endtask

	task automatic send_patch(input int p, input int max_gap);
		int gap;
		for (int b = 0; b < TMPL_WORDS; b++) begin
			gap = int'($urandom % 32'(max_gap + 1));
			repeat (gap) begin
				@(negedge clk);
				pix_valid = 1'b0;
			end
			@(negedge clk);
			pix_valid = 1'b1;
			pix_data  = {img[p][4*b+3], img[p][4*b+2], img[p][4*b+1], img[p][4*b]};
		end
		@(negedge clk);
		pix_valid = 1'b0;
	endtask

	task automatic run_frame(input bit tie, input int max_gap);
		int s [NUM_PATCHES];
		int idx;
		for (int p = 0; p < NUM_PATCHES; p++) begin
			for (int k = 0; k < PATCH_PX; k++) begin
				img[p][k] = (tie && p >= 2) ? img[p-2][k] : 8'($urandom);	// a b a b.
			end
			s[p] = ref_score(p);
			exp_scores.push_back(s[p]);
		end
		idx = best_of(s);
		exp_best.push_back(s[idx]);
		exp_index.push_back(idx);
		for (int p = 0; p < NUM_PATCHES; p++) begin
			send_patch(p, max_gap);
		end
		while (exp_scores.size() != 0 || exp_best.size() != 0) begin
			@(negedge clk);
		end
	endtask

	// compare process, samples well after the inputs move.
	initial begin
		forever begin
			@(negedge clk);
			#10;
			if (score_valid) begin
				if (exp_scores.size() == 0) begin
					abort("score_valid came with no patch outstanding");
				end else begin
					check("score", int'(score), exp_scores.pop_front());
				end
			end
			if (result_valid) begin
				if (exp_best.size() == 0) begin
					abort("result_valid came with no frame outstanding");
				end else begin
					check("best_score", int'(best_score), exp_best.pop_front());
					check("best_index", int'(best_index), exp_index.pop_front());
				end
			end
		end
	end

	initial begin
		cyc = 0;
		forever begin
			@(posedge clk);
			cyc++;
			if (cyc >= MAX_CYCLES) begin
				$display("TEST FAILED");
				$fatal(1, "timeout, the test did not finish within %0d cycles", cyc);
			end
		end
	end

	initial begin
		void'($urandom(32'h7c2d9523));
		rst_n     = 1'b0;
		en        = 1'b0;
		tm_wr     = 1'b0;
		tm_addr   = '0;
		tm_wdata  = '0;
		pix_valid = 1'b0;
		pix_data  = '0;
		tmpl_avg  = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		#10;
		check("ack", int'(ack), 0);
		check("done", int'(done), 0);
		check("score_valid", int'(score_valid), 0);
		check("result_valid", int'(result_valid), 0);

		// nothing loaded yet, so a whole patch must vanish.
		for (int k = 0; k < PATCH_PX; k++) begin
			img[0][k] = 8'($urandom);
		end
		send_patch(0, 0);
		repeat (4) @(negedge clk);

		write_template(8'($urandom));
		load_template();
		run_frame(1'b0, 1);
		run_frame(1'b1, 0);

		write_template(tmpl_avg ^ 8'h80);	// new average, far from the old one.
		load_template();
		run_frame(1'b0, 1);

		repeat (4) @(negedge clk);
		if (exp_scores.size() == 0 && exp_best.size() == 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			$display("TEST FAILED");
			$fatal(1, "some expected scores were never reported");
		end
	end

endmodule : template_matcher_tb

`default_nettype wire

// File: template_matcher.f
rtl/tm_pkg.sv
rtl/template_mem.sv
rtl/template_handler.sv
rtl/template_store.sv
rtl/patch_correlator.sv
rtl/peak_tracker.sv
rtl/template_matcher.sv
tb/template_matcher_assertions.sv
tb/template_matcher_tb.sv
